//--- Makefile
SRCS := $(shell cat tb.f)

obj_dir/Vpong_tb: tb.f $(SRCS)
	verilator --binary --timing --assert --top-module pong_tb -Mdir obj_dir -f tb.f

run: obj_dir/Vpong_tb
	./obj_dir/Vpong_tb | tee sim.log
	grep -q "RESULT: PASS" sim.log
	! grep -q "RESULT: FAIL" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- bench/pong_props.sv
`timescale 1ns/1ps
`default_nettype none

module pong_props (
	input logic clk,
	input logic resetn,
	input pong_pkg::wb_req_t bus_req,
	input pong_pkg::wb_rsp_t bus_rsp,
	input pong_pkg::pixel_t pixel,
	input logic lhs_scored,
	input logic rhs_scored
);

	ack_single: assert property (@(posedge clk) disable iff (!resetn)
		bus_rsp.ack |=> !bus_rsp.ack)
		else $error("ack held high for two cycles");

	ack_after_stb: assert property (@(posedge clk) disable iff (!resetn)
		bus_rsp.ack |-> $past(bus_req.cyc && bus_req.stb))
		else $error("ack without a preceding strobe");

	// plotted pixels stay on screen
	plot_on_screen: assert property (@(posedge clk) disable iff (!resetn)
		pixel.plot |-> (pixel.x <= pong_pkg::SCREEN_W - 1) && (pixel.y <= pong_pkg::SCREEN_H - 1))
		else $error("pixel plotted off screen");

	// a point is one pulse on one side only
	one_score: assert property (@(posedge clk) disable iff (!resetn)
		(lhs_scored || rhs_scored) |-> !(lhs_scored && rhs_scored) &&
			!$past(lhs_scored || rhs_scored))
		else $error("scoring outputs not a single one-sided pulse");

endmodule

bind pong_top pong_props pong_props_inst (
	.clk(clk),
	.resetn(resetn),
	.bus_req(bus_req),
	.bus_rsp(bus_rsp),
	.pixel(pixel),
	.lhs_scored(lhs_scored),
	.rhs_scored(rhs_scored)
);

`default_nettype wire

//--- bench/pong_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pong_tb;

	localparam int FRAME_CYCLES = 1000;
	localparam int DISABLED_PERIODS = 5;
	localparam int PADDLE_FRAMES = 70;
	localparam int BALL_FRAMES = 100;
	localparam int SCORE_FRAMES = 200;
	// disabled wait, three structure frames, then the motion tests
	localparam int MAX_FRAMES = DISABLED_PERIODS + 3 + PADDLE_FRAMES + BALL_FRAMES +
		SCORE_FRAMES;
	localparam int CYCLE_LIMIT = MAX_FRAMES * FRAME_CYCLES + 20000;

	logic clk;
	logic resetn;
	pong_pkg::wb_req_t bus_req;
	pong_pkg::wb_rsp_t bus_rsp;
	pong_pkg::paddle_btn_t player1;
	pong_pkg::paddle_btn_t player2;
	pong_pkg::pixel_t pixel;
	logic lhs_scored;
	logic rhs_scored;
	logic wall_hit;

	int cycles = 0;
	int test_errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;

	// monitor state, one entry per phase
	int frames_seen = 0;
	int total_plots = 0;
	int ph = 0;
	bit in_run = 0;
	int w_xmin [6];
	int w_ymin [6];
	int w_xmax [6];
	int w_ymax [6];
	int w_cnt [6];
	int w_col [6];
	bit w_mixed [6];
	bit ev_wall = 0;
	bit ev_lhs = 0;
	bit ev_rhs = 0;
	int cap_xmin [6];
	int cap_ymin [6];
	int cap_xmax [6];
	int cap_ymax [6];
	int cap_cnt [6];
	int cap_col [6];
	bit cap_mixed [6];
	bit cap_wall;
	bit cap_lhs;
	bit cap_rhs;
	int prev_x [6];
	int prev_y [6];
	bit have_prev = 0;

	// reference model
	int m_p1 = pong_pkg::PADDLE_Y0;
	int m_p2 = pong_pkg::PADDLE_Y0;
	int m_old_p1 = pong_pkg::PADDLE_Y0;
	int m_old_p2 = pong_pkg::PADDLE_Y0;
	int m_bx = pong_pkg::BALL_X0;
	int m_by = pong_pkg::BALL_Y0;
	int m_old_bx = pong_pkg::BALL_X0;
	int m_old_by = pong_pkg::BALL_Y0;
	bit m_dx = 1;
	bit m_dy = 1;
	bit m_wall;
	bit m_lhs;
	bit m_rhs;
	int m_colour = 7;

	pong_top pong_top_inst (
		.clk, .resetn, .bus_req, .bus_rsp, .player1, .player2,
		.pixel, .lhs_scored, .rhs_scored, .wall_hit
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$finish;
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT)
			abort_run("run stopped at the cycle limit before the tests finished");
	end

	// pixel monitor, one box per rasterizer run
	always @(negedge clk) begin
		if (lhs_scored)
			ev_lhs = 1;
		if (rhs_scored)
			ev_rhs = 1;
		if (wall_hit)
			ev_wall = 1;
		if (pixel.plot === 1'b1) begin
			total_plots++;
			if (!in_run) begin
				w_xmin[ph] = pixel.x;
				w_xmax[ph] = pixel.x;
				w_ymin[ph] = pixel.y;
				w_ymax[ph] = pixel.y;
				w_cnt[ph] = 0;
				w_col[ph] = pixel.colour;
				w_mixed[ph] = 0;
				in_run = 1;
			end
			if (pixel.x < w_xmin[ph]) w_xmin[ph] = pixel.x;
			if (pixel.x > w_xmax[ph]) w_xmax[ph] = pixel.x;
			if (pixel.y < w_ymin[ph]) w_ymin[ph] = pixel.y;
			if (pixel.y > w_ymax[ph]) w_ymax[ph] = pixel.y;
			if (pixel.colour != w_col[ph]) w_mixed[ph] = 1;
			w_cnt[ph]++;
		end else if (in_run) begin
			in_run = 0;
			ph++;
			if (ph == 6) begin
				for (int k = 0; k < 6; k++) begin
					cap_xmin[k] = w_xmin[k];
					cap_ymin[k] = w_ymin[k];
					cap_xmax[k] = w_xmax[k];
					cap_ymax[k] = w_ymax[k];
					cap_cnt[k] = w_cnt[k];
					cap_col[k] = w_col[k];
					cap_mixed[k] = w_mixed[k];
				end
				cap_wall = ev_wall;
				cap_lhs = ev_lhs;
				cap_rhs = ev_rhs;
				ev_wall = 0;
				ev_lhs = 0;
				ev_rhs = 0;
				ph = 0;
				frames_seen++;
			end
		end
	end

	function automatic int paddle_next(input int y, input pong_pkg::paddle_btn_t b);
		if (b.up && !b.down)
			return (y - pong_pkg::PADDLE_STEP < pong_pkg::PADDLE_Y_MIN) ?
				pong_pkg::PADDLE_Y_MIN : y - pong_pkg::PADDLE_STEP;
		if (b.down && !b.up)
			return (y + pong_pkg::PADDLE_STEP > pong_pkg::PADDLE_Y_MAX) ?
				pong_pkg::PADDLE_Y_MAX : y + pong_pkg::PADDLE_STEP;
		return y;
	endfunction

	// one frame of paddle and ball motion
	function automatic void model_step(input pong_pkg::paddle_btn_t b1,
			input pong_pkg::paddle_btn_t b2);
		int nx;
		int ny;
		int face_y;
		int ball_bot;
		int pad_bot;
		bit reach;
		bit hit;
		m_old_bx = m_bx;
		m_old_by = m_by;
		m_old_p1 = m_p1;
		m_old_p2 = m_p2;
		m_wall = 0;
		m_lhs = 0;
		m_rhs = 0;
		ny = m_dy ? m_by + pong_pkg::BALL_STEP : m_by - pong_pkg::BALL_STEP;
		if (m_dy && ny >= pong_pkg::BALL_Y_MAX) begin
			ny = pong_pkg::BALL_Y_MAX;
			m_wall = 1;
		end else if (!m_dy && ny <= pong_pkg::Y_MARGIN) begin
			ny = pong_pkg::Y_MARGIN;
			m_wall = 1;
		end
		nx = m_dx ? m_bx + pong_pkg::BALL_STEP : m_bx - pong_pkg::BALL_STEP;
		reach = m_dx ? (nx >= pong_pkg::BALL_X_MAX) : (nx <= pong_pkg::BALL_X_MIN);
		face_y = m_dx ? m_p2 : m_p1;
		ball_bot = m_by + pong_pkg::BALL_SIZE - 1;
		pad_bot = face_y + pong_pkg::PADDLE_H - 1;
		// spans overlap when each starts before the other ends
		hit = (ball_bot >= face_y) && (pad_bot >= m_by);
		if (reach && hit) begin
			nx = m_dx ? pong_pkg::BALL_X_MAX : pong_pkg::BALL_X_MIN;
		end else if (reach) begin
			nx = pong_pkg::BALL_X0;
			ny = pong_pkg::BALL_Y0;
			m_lhs = m_dx;
			m_rhs = !m_dx;
		end
		if (reach)
			m_dx = !m_dx;
		if (m_wall)
			m_dy = !m_dy;
		m_bx = nx;
		m_by = ny;
		m_p1 = paddle_next(m_p1, b1);
		m_p2 = paddle_next(m_p2, b2);
	endfunction

	task automatic check_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Fail %s: expected %0d, actual %0d", what, expected, actual);
			test_errors++;
		end
	endtask

	task automatic finish_test(input string name);
		if (test_errors == 0) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, test_errors);
		end
		test_errors = 0;
	endtask

	task automatic bus_cycle(input bit we, input pong_pkg::wb_addr_t adr,
			input logic [31:0] wdata, output logic [31:0] rdata);
		int waited;
		waited = 0;
		@(negedge clk);
		bus_req.cyc = 1;
		bus_req.stb = 1;
		bus_req.we = we;
		bus_req.adr = adr;
		bus_req.dat_w = wdata;
		do begin
			@(negedge clk);
			waited++;
			if (waited > 10)
				abort_run("bus cycle got no ack");
		end while (bus_rsp.ack !== 1'b1);
		rdata = bus_rsp.dat_r;
		bus_req.cyc = 0;
		bus_req.stb = 0;
		bus_req.we = 0;
	endtask

	task automatic bus_write(input pong_pkg::wb_addr_t adr, input logic [31:0] data);
		logic [31:0] unused;
		bus_cycle(1, adr, data, unused);
	endtask

	task automatic bus_read_check(input string what, input pong_pkg::wb_addr_t adr,
			input logic [31:0] expected);
		logic [31:0] data;
		bus_cycle(0, adr, '0, data);
		check_value(what, expected, data);
	endtask

	task automatic wait_frame();
		int start_count;
		int waited;
		start_count = frames_seen;
		waited = 0;
		while (frames_seen == start_count) begin
			@(posedge clk);
			waited++;
			if (waited > 3 * FRAME_CYCLES)
				abort_run("no frame completed within three frame periods");
		end
	endtask

	task automatic check_frame(input string name);
		int ex [6];
		int ey [6];
		int ew [6];
		int eh [6];
		int ec [6];
		string tag;
		ex = '{pong_pkg::PADDLE1_X, pong_pkg::PADDLE1_X, pong_pkg::PADDLE2_X,
			pong_pkg::PADDLE2_X, m_old_bx, m_bx};
		ey = '{m_old_p1, m_p1, m_old_p2, m_p2, m_old_by, m_by};
		for (int k = 0; k < 6; k++) begin
			ew[k] = (k < 4) ? pong_pkg::PADDLE_W : pong_pkg::BALL_SIZE;
			eh[k] = (k < 4) ? pong_pkg::PADDLE_H : pong_pkg::BALL_SIZE;
			// even phases clear, odd phases draw
			ec[k] = (k % 2 == 1) ? m_colour : 0;
		end
		for (int k = 0; k < 6; k++) begin
			tag = $sformatf("%s frame %0d phase %0d", name, frames_seen, k);
			check_value({tag, " x"}, ex[k], cap_xmin[k]);
			check_value({tag, " y"}, ey[k], cap_ymin[k]);
			check_value({tag, " right"}, ex[k] + ew[k] - 1, cap_xmax[k]);
			check_value({tag, " bottom"}, ey[k] + eh[k] - 1, cap_ymax[k]);
			check_value({tag, " count"}, ew[k] * eh[k], cap_cnt[k]);
			check_value({tag, " colour"}, ec[k], cap_col[k]);
			check_value({tag, " colour mixed"}, 0, cap_mixed[k]);
			if (have_prev && k % 2 == 0) begin
				check_value({tag, " clear x vs last draw"}, prev_x[k + 1], cap_xmin[k]);
				check_value({tag, " clear y vs last draw"}, prev_y[k + 1], cap_ymin[k]);
			end
		end
		for (int k = 0; k < 6; k++) begin
			prev_x[k] = cap_xmin[k];
			prev_y[k] = cap_ymin[k];
		end
		have_prev = 1;
		check_value({name, " wall_hit"}, m_wall, cap_wall);
		check_value({name, " lhs_scored"}, m_lhs, cap_lhs);
		check_value({name, " rhs_scored"}, m_rhs, cap_rhs);
	endtask

	task automatic run_frame(input string name, input pong_pkg::paddle_btn_t b1,
			input pong_pkg::paddle_btn_t b2);
		@(negedge clk);
		player1 = b1;
		player2 = b2;
		model_step(b1, b2);
		wait_frame();
		check_frame(name);
	endtask

	initial begin
		pong_pkg::paddle_btn_t b1;
		pong_pkg::paddle_btn_t b2;
		bit seen_min;
		bit seen_max;
		bit scored;
		int n;
		resetn = 0;
		bus_req = '0;
		player1 = '0;
		player2 = '0;
		void'($urandom(32'he0bc_54e7));
		repeat (3) @(posedge clk);
		@(negedge clk);
		resetn = 1;

		bus_read_check("reset ctrl", pong_pkg::REG_CTRL, 0);
		bus_read_check("reset colour", pong_pkg::REG_COLOUR, 7);
		bus_read_check("reset period", pong_pkg::REG_PERIOD, pong_pkg::FRAME_PERIOD_RESET);
		bus_write(pong_pkg::REG_PERIOD, FRAME_CYCLES);
		bus_write(pong_pkg::REG_COLOUR, 5);
		bus_write(2'd3, 32'hffff);
		bus_read_check("period readback", pong_pkg::REG_PERIOD, FRAME_CYCLES);
		bus_read_check("colour readback", pong_pkg::REG_COLOUR, 5);
		bus_read_check("unmapped read", 2'd3, 0);
		finish_test("register_access");

		m_colour = 5;
		repeat (DISABLED_PERIODS * FRAME_CYCLES) @(posedge clk);
		check_value("plots while disabled", 0, total_plots);
		bus_write(pong_pkg::REG_CTRL, 1);
		bus_read_check("ctrl readback", pong_pkg::REG_CTRL, 1);
		run_frame("enable", '0, '0);
		finish_test("disabled_game");

		bus_write(pong_pkg::REG_COLOUR, 3);
		m_colour = 3;
		run_frame("colour 3", '0, '0);
		bus_write(pong_pkg::REG_COLOUR, 6);
		m_colour = 6;
		run_frame("colour 6", '0, '0);
		finish_test("frame_structure");

		seen_min = 0;
		seen_max = 0;
		for (int f = 0; f < PADDLE_FRAMES; f++) begin
			// mostly one direction per half so both clamps are reached
			b1 = (f < PADDLE_FRAMES / 2) ? 2'b10 : 2'b01;
			b2 = (f < PADDLE_FRAMES / 2) ? 2'b01 : 2'b10;
			if ($urandom % 8 == 0)
				b1 = 2'($urandom);
			if ($urandom % 8 == 0)
				b2 = 2'($urandom);
			run_frame("paddle", b1, b2);
			// drawn paddle tops are phases 1 and 3
			if (cap_ymin[1] == pong_pkg::PADDLE_Y_MIN || cap_ymin[3] == pong_pkg::PADDLE_Y_MIN)
				seen_min = 1;
			if (cap_ymin[1] == pong_pkg::PADDLE_Y_MAX || cap_ymin[3] == pong_pkg::PADDLE_Y_MAX)
				seen_max = 1;
		end
		check_value("paddle reached top clamp", 1, seen_min);
		check_value("paddle reached bottom clamp", 1, seen_max);
		finish_test("paddle_motion");

		n = 0;
		for (int f = 0; f < BALL_FRAMES; f++) begin
			run_frame("ball", '0, '0);
			if (cap_wall)
				n++;
		end
		check_value("ball wall bounces", 1, n > 0);
		finish_test("ball_flight");

		scored = 0;
		for (int f = 0; f < SCORE_FRAMES && !scored; f++) begin
			// paddles go to the end away from the ball
			b1 = (m_by < pong_pkg::SCREEN_H / 2) ? 2'b01 : 2'b10;
			run_frame("score", b1, b1);
			if (m_lhs || m_rhs) begin
				scored = 1;
				check_value("score ball x", pong_pkg::BALL_X0, cap_xmin[5]);
				check_value("score ball y", pong_pkg::BALL_Y0, cap_ymin[5]);
			end
		end
		check_value("score happened", 1, scored);
		finish_test("scoring");

		$display("tests passed %0d, failed %0d", tests_passed, tests_failed);
		if (tests_failed == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- common/pong_pkg.sv
`default_nettype none

package pong_pkg;

	typedef logic [8:0] coord_x_t;
	typedef logic [7:0] coord_y_t;
	typedef logic [2:0] colour_t;
	typedef logic [19:0] period_t;
	typedef logic [31:0] wb_data_t;
	typedef logic [1:0] wb_addr_t;

	// screen and object geometry
	localparam int SCREEN_W = 320;
	localparam int SCREEN_H = 240;
	localparam int Y_MARGIN = 20;
	localparam int PADDLE_W = 5;
	localparam int PADDLE_H = 40;
	localparam int PADDLE1_X = 2;
	localparam int PADDLE2_X = SCREEN_W - PADDLE_W;
	localparam int BALL_SIZE = 4;
	localparam int PADDLE_STEP = 3;
	localparam int BALL_STEP = 2;
	localparam int PADDLE_Y_MIN = Y_MARGIN;
	localparam int PADDLE_Y_MAX = SCREEN_H - 1 - PADDLE_H - Y_MARGIN;
	localparam int PADDLE_Y0 = (PADDLE_Y_MIN + PADDLE_Y_MAX) / 2;
	localparam int BALL_Y_MAX = SCREEN_H - 1 - BALL_SIZE - Y_MARGIN;
	localparam int BALL_X0 = (SCREEN_W - BALL_SIZE) / 2;
	localparam int BALL_Y0 = (SCREEN_H - BALL_SIZE) / 2;
	// ball x positions touching the paddle faces
	localparam int BALL_X_MIN = PADDLE1_X + PADDLE_W;
	localparam int BALL_X_MAX = PADDLE2_X - BALL_SIZE;

	localparam int FRAME_PERIOD_RESET = 833333;
	localparam int DRAW_COLOUR_RESET = 7;

	// register map, word addresses
	localparam wb_addr_t REG_CTRL = 2'd0;
	localparam wb_addr_t REG_COLOUR = 2'd1;
	localparam wb_addr_t REG_PERIOD = 2'd2;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		wb_addr_t adr;
		wb_data_t dat_w;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		wb_data_t dat_r;
	} wb_rsp_t;

	typedef struct packed {
		logic up;
		logic down;
	} paddle_btn_t;

	typedef struct packed {
		coord_x_t x;
		coord_y_t y;
		colour_t colour;
		logic plot;
	} pixel_t;

	typedef enum logic [3:0] {
		IDLE,
		CLR_P1_START,
		CLR_P1_RUN,
		DRW_P1_START,
		DRW_P1_RUN,
		CLR_P2_START,
		CLR_P2_RUN,
		DRW_P2_START,
		DRW_P2_RUN,
		CLR_BALL_START,
		CLR_BALL_RUN,
		DRW_BALL_START,
		DRW_BALL_RUN
	} render_state_t;

endpackage

`default_nettype wire

//--- game/ball_motion.sv
`timescale 1ns/1ps
`default_nettype none

module ball_motion (
	input logic clk,
	input logic resetn,
	input logic frame_start,
	input pong_pkg::coord_y_t paddle1_y,
	input pong_pkg::coord_y_t paddle2_y,
	output pong_pkg::coord_x_t ball_x,
	output pong_pkg::coord_y_t ball_y,
	output pong_pkg::coord_x_t old_ball_x,
	output pong_pkg::coord_y_t old_ball_y,
	output logic lhs_scored,
	output logic rhs_scored,
	output logic wall_hit
);

	// direction bits, 1 is toward positive x or y
	logic dir_x;
	logic dir_y;
	logic y_bounce;
	logic x_reach;
	logic overlap;
	logic miss;
	pong_pkg::coord_y_t face_paddle_y;
	pong_pkg::coord_x_t next_x;
	pong_pkg::coord_y_t next_y;

	always_comb begin
		if (dir_y)
			y_bounce = ball_y >= pong_pkg::BALL_Y_MAX - pong_pkg::BALL_STEP;
		else
			y_bounce = ball_y <= pong_pkg::Y_MARGIN + pong_pkg::BALL_STEP;

		if (dir_x)
			x_reach = ball_x >= pong_pkg::BALL_X_MAX - pong_pkg::BALL_STEP;
		else
			x_reach = ball_x <= pong_pkg::BALL_X_MIN + pong_pkg::BALL_STEP;

		// paddle on the side the ball is heading to
		face_paddle_y = dir_x ? paddle2_y : paddle1_y;
		overlap = (ball_y + pong_pkg::BALL_SIZE > face_paddle_y) &&
			(face_paddle_y + pong_pkg::PADDLE_H > ball_y);
		miss = x_reach && !overlap;

		if (y_bounce)
			next_y = pong_pkg::coord_y_t'(dir_y ? pong_pkg::BALL_Y_MAX : pong_pkg::Y_MARGIN);
		else if (dir_y)
			next_y = pong_pkg::coord_y_t'(ball_y + pong_pkg::BALL_STEP);
		else
			next_y = pong_pkg::coord_y_t'(ball_y - pong_pkg::BALL_STEP);

		if (!x_reach) begin
			if (dir_x)
				next_x = pong_pkg::coord_x_t'(ball_x + pong_pkg::BALL_STEP);
			else
				next_x = pong_pkg::coord_x_t'(ball_x - pong_pkg::BALL_STEP);
		end else if (overlap) begin
			next_x = pong_pkg::coord_x_t'(dir_x ? pong_pkg::BALL_X_MAX : pong_pkg::BALL_X_MIN);
		end else begin
			next_x = pong_pkg::coord_x_t'(pong_pkg::BALL_X0);
			next_y = pong_pkg::coord_y_t'(pong_pkg::BALL_Y0);
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			ball_x <= pong_pkg::coord_x_t'(pong_pkg::BALL_X0);
			ball_y <= pong_pkg::coord_y_t'(pong_pkg::BALL_Y0);
			old_ball_x <= pong_pkg::coord_x_t'(pong_pkg::BALL_X0);
			old_ball_y <= pong_pkg::coord_y_t'(pong_pkg::BALL_Y0);
			dir_x <= 1'b1;
			dir_y <= 1'b1;
			lhs_scored <= 1'b0;
			rhs_scored <= 1'b0;
			wall_hit <= 1'b0;
		end else begin
			lhs_scored <= 1'b0;
			rhs_scored <= 1'b0;
			wall_hit <= 1'b0;
			if (frame_start) begin
				old_ball_x <= ball_x;
				old_ball_y <= ball_y;
				ball_x <= next_x;
				ball_y <= next_y;
				dir_x <= dir_x ^ x_reach;
				dir_y <= dir_y ^ y_bounce;
				wall_hit <= y_bounce;
				// a miss on the right side is a point for the left player
				lhs_scored <= miss && dir_x;
				rhs_scored <= miss && !dir_x;
			end
		end
	end

endmodule

`default_nettype wire

//--- game/paddle_motion.sv
`timescale 1ns/1ps
`default_nettype none

module paddle_motion (
	input logic clk,
	input logic resetn,
	input logic frame_start,
	input pong_pkg::paddle_btn_t buttons,
	output pong_pkg::coord_y_t paddle_y,
	output pong_pkg::coord_y_t old_paddle_y
);

	pong_pkg::coord_y_t next_y;

	always_comb begin
		next_y = paddle_y;
		if (buttons.up && !buttons.down) begin
			if (paddle_y <= pong_pkg::PADDLE_Y_MIN + pong_pkg::PADDLE_STEP)
				next_y = pong_pkg::coord_y_t'(pong_pkg::PADDLE_Y_MIN);
			else
				next_y = pong_pkg::coord_y_t'(paddle_y - pong_pkg::PADDLE_STEP);
		end else if (buttons.down && !buttons.up) begin
			if (paddle_y >= pong_pkg::PADDLE_Y_MAX - pong_pkg::PADDLE_STEP)
				next_y = pong_pkg::coord_y_t'(pong_pkg::PADDLE_Y_MAX);
			else
				next_y = pong_pkg::coord_y_t'(paddle_y + pong_pkg::PADDLE_STEP);
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			paddle_y <= pong_pkg::coord_y_t'(pong_pkg::PADDLE_Y0);
			old_paddle_y <= pong_pkg::coord_y_t'(pong_pkg::PADDLE_Y0);
		end else if (frame_start) begin
			// old position is what the clear phase erases
			old_paddle_y <= paddle_y;
			paddle_y <= next_y;
		end
	end

endmodule

`default_nettype wire

//--- logic/frame_timer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_timer (
	input logic clk,
	input logic resetn,
	input logic game_enable,
	input pong_pkg::period_t frame_period,
	output logic frame_tick
);

	pong_pkg::period_t count;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			count <= pong_pkg::period_t'(pong_pkg::FRAME_PERIOD_RESET - 1);
			frame_tick <= 1'b0;
		end else if (!game_enable) begin
			// parked at the top of the period until enabled
			count <= frame_period - 1'b1;
			frame_tick <= 1'b0;
		end else if (count == '0) begin
			count <= frame_period - 1'b1;
			frame_tick <= 1'b1;
		end else begin
			count <= count - 1'b1;
			frame_tick <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- logic/game_regs.sv
`timescale 1ns/1ps
`default_nettype none

module game_regs (
	input logic clk,
	input logic resetn,
	input pong_pkg::wb_req_t bus_req,
	output pong_pkg::wb_rsp_t bus_rsp,
	output logic game_enable,
	output pong_pkg::colour_t draw_colour,
	output pong_pkg::period_t frame_period
);

	logic ack;
	logic req;
	pong_pkg::wb_data_t rd_data;

	// new request, not the tail of the one being acked
	assign req = bus_req.cyc && bus_req.stb && !ack;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			ack <= 1'b0;
			game_enable <= 1'b0;
			draw_colour <= pong_pkg::colour_t'(pong_pkg::DRAW_COLOUR_RESET);
			frame_period <= pong_pkg::period_t'(pong_pkg::FRAME_PERIOD_RESET);
		end else begin
			ack <= req;
			if (req && bus_req.we) begin
				case (bus_req.adr)
					pong_pkg::REG_CTRL: game_enable <= bus_req.dat_w[0];
					pong_pkg::REG_COLOUR: draw_colour <= bus_req.dat_w[2:0];
					pong_pkg::REG_PERIOD: frame_period <= bus_req.dat_w[19:0];
					default: ;
				endcase
			end
		end
	end

	// read mux, address held stable by the master through ack
	always_comb begin
		rd_data = '0;
		case (bus_req.adr)
			pong_pkg::REG_CTRL: rd_data[0] = game_enable;
			pong_pkg::REG_COLOUR: rd_data[2:0] = draw_colour;
			pong_pkg::REG_PERIOD: rd_data[19:0] = frame_period;
			default: rd_data = '0;
		endcase
	end

	assign bus_rsp.ack = ack;
	assign bus_rsp.dat_r = rd_data;

endmodule

`default_nettype wire

//--- logic/pong_top.sv
`timescale 1ns/1ps
`default_nettype none

module pong_top (
	input logic clk,
	input logic resetn,
	input pong_pkg::wb_req_t bus_req,
	output pong_pkg::wb_rsp_t bus_rsp,
	input pong_pkg::paddle_btn_t player1,
	input pong_pkg::paddle_btn_t player2,
	output pong_pkg::pixel_t pixel,
	output logic lhs_scored,
	output logic rhs_scored,
	output logic wall_hit
);

	logic game_enable;
	pong_pkg::colour_t draw_colour;
	pong_pkg::period_t frame_period;
	logic frame_tick;
	logic frame_start;
	pong_pkg::coord_y_t paddle1_y;
	pong_pkg::coord_y_t old_paddle1_y;
	pong_pkg::coord_y_t paddle2_y;
	pong_pkg::coord_y_t old_paddle2_y;
	pong_pkg::coord_x_t ball_x;
	pong_pkg::coord_x_t old_ball_x;
	pong_pkg::coord_y_t ball_y;
	pong_pkg::coord_y_t old_ball_y;
	logic raster_start;
	logic raster_done;
	pong_pkg::coord_x_t box_x;
	pong_pkg::coord_y_t box_y;
	pong_pkg::coord_x_t box_w;
	pong_pkg::coord_y_t box_h;
	pong_pkg::colour_t box_colour;

	game_regs game_regs_inst (
		.clk, .resetn, .bus_req, .bus_rsp,
		.game_enable, .draw_colour, .frame_period
	);

	frame_timer frame_timer_inst (
		.clk, .resetn, .game_enable, .frame_period, .frame_tick
	);

	paddle_motion paddle1_inst (
		.clk, .resetn, .frame_start,
		.buttons(player1),
		.paddle_y(paddle1_y),
		.old_paddle_y(old_paddle1_y)
	);

	paddle_motion paddle2_inst (
		.clk, .resetn, .frame_start,
		.buttons(player2),
		.paddle_y(paddle2_y),
		.old_paddle_y(old_paddle2_y)
	);

	// sees the paddle positions from before this frame's update
	ball_motion ball_motion_inst (
		.clk, .resetn, .frame_start, .paddle1_y, .paddle2_y,
		.ball_x, .ball_y, .old_ball_x, .old_ball_y,
		.lhs_scored, .rhs_scored, .wall_hit
	);

	render_sequencer render_sequencer_inst (
		.clk, .resetn, .frame_tick, .draw_colour,
		.paddle1_y, .old_paddle1_y, .paddle2_y, .old_paddle2_y,
		.ball_x, .old_ball_x, .ball_y, .old_ball_y,
		.raster_done, .frame_start, .raster_start,
		.box_x, .box_y, .box_w, .box_h, .box_colour
	);

	box_raster box_raster_inst (
		.clk, .resetn, .raster_start,
		.box_x, .box_y, .box_w, .box_h, .box_colour,
		.pixel, .raster_done
	);

endmodule

`default_nettype wire

//--- render/box_raster.sv
`timescale 1ns/1ps
`default_nettype none

module box_raster (
	input logic clk,
	input logic resetn,
	input logic raster_start,
	input pong_pkg::coord_x_t box_x,
	input pong_pkg::coord_y_t box_y,
	input pong_pkg::coord_x_t box_w,
	input pong_pkg::coord_y_t box_h,
	input pong_pkg::colour_t box_colour,
	output pong_pkg::pixel_t pixel,
	output logic raster_done
);

	pong_pkg::coord_x_t org_x;
	pong_pkg::coord_y_t org_y;
	pong_pkg::coord_x_t width;
	pong_pkg::coord_y_t height;
	pong_pkg::colour_t colour;
	pong_pkg::coord_x_t col;
	pong_pkg::coord_y_t row;
	logic busy;
	logic last;

	// box latched once per run
	always_ff @(posedge clk) begin
		if (raster_start) begin
			org_x <= box_x;
			org_y <= box_y;
			width <= box_w;
			height <= box_h;
			colour <= box_colour;
		end
	end

	assign last = (col == width - 1'b1) && (row == height - 1'b1);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			busy <= 1'b0;
			col <= '0;
			row <= '0;
		end else if (raster_start) begin
			busy <= 1'b1;
			col <= '0;
			row <= '0;
		end else if (busy) begin
			if (last) begin
				busy <= 1'b0;
			end else if (col == width - 1'b1) begin
				// end of row, back to the left edge
				col <= '0;
				row <= row + 1'b1;
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	assign pixel.x = org_x + col;
	assign pixel.y = org_y + row;
	assign pixel.colour = colour;
	assign pixel.plot = busy;
	assign raster_done = busy && last;

endmodule

`default_nettype wire

//--- render/render_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module render_sequencer (
	input logic clk,
	input logic resetn,
	input logic frame_tick,
	input pong_pkg::colour_t draw_colour,
	input pong_pkg::coord_y_t paddle1_y,
	input pong_pkg::coord_y_t old_paddle1_y,
	input pong_pkg::coord_y_t paddle2_y,
	input pong_pkg::coord_y_t old_paddle2_y,
	input pong_pkg::coord_x_t ball_x,
	input pong_pkg::coord_x_t old_ball_x,
	input pong_pkg::coord_y_t ball_y,
	input pong_pkg::coord_y_t old_ball_y,
	input logic raster_done,
	output logic frame_start,
	output logic raster_start,
	output pong_pkg::coord_x_t box_x,
	output pong_pkg::coord_y_t box_y,
	output pong_pkg::coord_x_t box_w,
	output pong_pkg::coord_y_t box_h,
	output pong_pkg::colour_t box_colour
);

	pong_pkg::render_state_t state;
	pong_pkg::render_state_t next_state;

	always_ff @(posedge clk) begin
		if (!resetn)
			state <= pong_pkg::IDLE;
		else
			state <= next_state;
	end

	// ticks outside idle are dropped
	assign frame_start = (state == pong_pkg::IDLE) && frame_tick;

	always_comb begin
		next_state = state;
		raster_start = 1'b0;
		case (state)
			pong_pkg::IDLE: if (frame_tick) next_state = pong_pkg::CLR_P1_START;
			pong_pkg::CLR_P1_START: begin
				raster_start = 1'b1;
				next_state = pong_pkg::CLR_P1_RUN;
			end
			pong_pkg::CLR_P1_RUN: if (raster_done) next_state = pong_pkg::DRW_P1_START;
			pong_pkg::DRW_P1_START: begin
				raster_start = 1'b1;
				next_state = pong_pkg::DRW_P1_RUN;
			end
			pong_pkg::DRW_P1_RUN: if (raster_done) next_state = pong_pkg::CLR_P2_START;
			pong_pkg::CLR_P2_START: begin
				raster_start = 1'b1;
				next_state = pong_pkg::CLR_P2_RUN;
			end
			pong_pkg::CLR_P2_RUN: if (raster_done) next_state = pong_pkg::DRW_P2_START;
			pong_pkg::DRW_P2_START: begin
				raster_start = 1'b1;
				next_state = pong_pkg::DRW_P2_RUN;
			end
			pong_pkg::DRW_P2_RUN: if (raster_done) next_state = pong_pkg::CLR_BALL_START;
			pong_pkg::CLR_BALL_START: begin
				raster_start = 1'b1;
				next_state = pong_pkg::CLR_BALL_RUN;
			end
			pong_pkg::CLR_BALL_RUN: if (raster_done) next_state = pong_pkg::DRW_BALL_START;
			pong_pkg::DRW_BALL_START: begin
				raster_start = 1'b1;
				next_state = pong_pkg::DRW_BALL_RUN;
			end
			pong_pkg::DRW_BALL_RUN: if (raster_done) next_state = pong_pkg::IDLE;
			default: next_state = pong_pkg::IDLE;
		endcase
	end

	// box of the current phase, sampled by the rasterizer in the start state
	always_comb begin
		box_x = pong_pkg::coord_x_t'(pong_pkg::PADDLE1_X);
		box_y = old_paddle1_y;
		box_w = pong_pkg::coord_x_t'(pong_pkg::PADDLE_W);
		box_h = pong_pkg::coord_y_t'(pong_pkg::PADDLE_H);
		box_colour = '0;
		case (state)
			pong_pkg::DRW_P1_START, pong_pkg::DRW_P1_RUN: begin
				box_y = paddle1_y;
				box_colour = draw_colour;
			end
			pong_pkg::CLR_P2_START, pong_pkg::CLR_P2_RUN: begin
				box_x = pong_pkg::coord_x_t'(pong_pkg::PADDLE2_X);
				box_y = old_paddle2_y;
			end
			pong_pkg::DRW_P2_START, pong_pkg::DRW_P2_RUN: begin
				box_x = pong_pkg::coord_x_t'(pong_pkg::PADDLE2_X);
				box_y = paddle2_y;
				box_colour = draw_colour;
			end
			pong_pkg::CLR_BALL_START, pong_pkg::CLR_BALL_RUN: begin
				box_x = old_ball_x;
				box_y = old_ball_y;
				box_w = pong_pkg::coord_x_t'(pong_pkg::BALL_SIZE);
				box_h = pong_pkg::coord_y_t'(pong_pkg::BALL_SIZE);
			end
			pong_pkg::DRW_BALL_START, pong_pkg::DRW_BALL_RUN: begin
				box_x = ball_x;
				box_y = ball_y;
				box_w = pong_pkg::coord_x_t'(pong_pkg::BALL_SIZE);
				box_h = pong_pkg::coord_y_t'(pong_pkg::BALL_SIZE);
				box_colour = draw_colour;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- tb.f
common/pong_pkg.sv
logic/game_regs.sv
logic/frame_timer.sv
game/paddle_motion.sv
game/ball_motion.sv
render/render_sequencer.sv
render/box_raster.sv
logic/pong_top.sv
bench/pong_props.sv
bench/pong_tb.sv
